// ==== design/if_config.svh ====
// Build-time sizing for the fetch stage; IF_BUF_DEPTH must stay >= IF_MAX_OUTSTANDING, seed nonzero
`ifndef IF_CONFIG_SVH
`define IF_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////////////////////////

// Address and instruction word width
`define IF_XLEN 32

//////////////////////////////////////////////////////////////////////
// Prefetch and bus limits
//////////////////////////////////////////////////////////////////////

// Prefetch FIFO entries
`define IF_BUF_DEPTH 3
// Granted requests still waiting for rvalid
`define IF_MAX_OUTSTANDING 2

// Dummy instruction LFSR start value, must never be zero
`define IF_LFSR_SEED 32'h1F3A_C5E7

`endif

// ==== design/if_ctrl_pkg.sv ====
// Controller-side types only; pc_mux codes 6 and 7 are unused and flagged by the PC mux
package if_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Next-PC source
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  //////////////////////////////////////////////////////////////////////
  // Controller command into IF
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       pc_set;     // Redirect this cycle
    pc_mux_e    pc_mux;     // Which target to take
    logic [4:0] irq_index;  // Vector slot for PC_TRAP_IRQ
    logic       kill_if;    // Drop what IF holds
    logic       halt_if;    // Hold IF output
  } ctrl_fsm_t;

endpackage

// ==== design/if_bus_pkg.sv ====
// Data-side records of the fetch path; word-aligned fetches only, no compressed instructions
`include "if_config.svh"

package if_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Instruction bus transactions
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`IF_XLEN-1:0] addr;
  } bus_req_t;

  typedef struct packed {
    logic [`IF_XLEN-1:0] rdata;
    logic                err;
  } bus_resp_t;

  // Fetched word tagged with the address it came from
  typedef struct packed {
    bus_resp_t           bus_resp;
    logic [`IF_XLEN-1:0] addr;
  } inst_resp_t;

  //////////////////////////////////////////////////////////////////////
  // IF/ID pipeline register
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                instr_valid;
    logic [`IF_XLEN-1:0] pc;
    logic [`IF_XLEN-1:0] instr;
    logic                dummy;     // Injected by the dummy inserter
    logic                abort_op;  // Bus error on this fetch
  } if_id_pipe_t;

endpackage

// ==== design/if_pc_mux.sv ====
// Purely combinational; every target is forced word aligned, mtvec base is bits 31:7 only
`include "if_config.svh"

module if_pc_mux (
  input  if_ctrl_pkg::ctrl_fsm_t ctrl_i,
  input  logic [`IF_XLEN-1:0]    boot_addr_i,
  input  logic [`IF_XLEN-1:0]    jump_target_i,
  input  logic [`IF_XLEN-1:0]    branch_target_i,
  input  logic [`IF_XLEN-1:0]    mepc_i,
  input  logic [24:0]            mtvec_base_i,
  output logic [`IF_XLEN-1:0]    target_o,
  output logic                   mtvec_init_o
);
  import if_ctrl_pkg::*;

  logic [`IF_XLEN-1:0] target_raw;

  // Target decode
  always_comb begin
    target_raw = boot_addr_i;
    case (ctrl_i.pc_mux)
      PC_BOOT:     target_raw = boot_addr_i;
      PC_JUMP:     target_raw = jump_target_i;
      PC_BRANCH:   target_raw = branch_target_i;
      // Return from trap
      PC_MRET:     target_raw = mepc_i;
      // Exceptions share the base
      PC_TRAP_EXC: target_raw = {mtvec_base_i, 7'h00};
      // Vectored, base + index * 4
      PC_TRAP_IRQ: target_raw = {mtvec_base_i, ctrl_i.irq_index, 2'b00};
      default:     target_raw = boot_addr_i;
    endcase
  end

  // No compressed support, so bits 1:0 never matter
  assign target_o = {target_raw[`IF_XLEN-1:2], 2'b00};

  // CSR file loads mtvec with the boot redirect
  assign mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_BOOT);

  // Controller must never redirect with an undefined source
  a_pc_mux_known: assert final (!ctrl_i.pc_set || ctrl_i.pc_mux inside
    {PC_BOOT, PC_JUMP, PC_BRANCH, PC_MRET, PC_TRAP_EXC, PC_TRAP_IRQ})
    else $error("pc_set with unknown pc_mux %0d", ctrl_i.pc_mux);

endmodule

// ==== design/if_instr_bus.sv ====
// Single-master req/gnt/rvalid adapter; responses must return in order, at least one cycle after gnt
`include "if_config.svh"

module if_instr_bus (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  trans_valid_i,
  input  if_bus_pkg::bus_req_t  trans_i,
  output logic                  trans_ready_o,
  output logic                  resp_valid_o,
  output if_bus_pkg::bus_resp_t resp_o,
  output logic                  req_o,
  output logic [`IF_XLEN-1:0]   addr_o,
  input  logic                  gnt_i,
  input  logic                  rvalid_i,
  input  logic                  err_i,
  input  logic [`IF_XLEN-1:0]   rdata_i,
  output logic                  protocol_err_o
);
  localparam int unsigned CNT_W = $clog2(`IF_MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0]    outstnd_q;
  logic                pend_q;       // Request out, no grant yet
  logic [`IF_XLEN-1:0] pend_addr_q;
  logic                granted;
  logic                resp_expected;

  // Accept only with a free slot and nothing waiting for grant
  assign trans_ready_o = !pend_q && (outstnd_q < CNT_W'(`IF_MAX_OUTSTANDING));

  // A waiting request keeps req and addr frozen until gnt
  assign req_o   = pend_q || (trans_valid_i && trans_ready_o);
  assign addr_o  = pend_q ? pend_addr_q : trans_i.addr;
  assign granted = req_o && gnt_i;

  // Responses
  assign resp_expected = (outstnd_q != '0);
  assign resp_valid_o  = rvalid_i && resp_expected;
  assign resp_o        = '{rdata: rdata_i, err: err_i};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q         <= 1'b0;
      outstnd_q      <= '0;
      protocol_err_o <= 1'b0;
    end else begin
      if (granted) begin
        pend_q <= 1'b0;
      end else if (req_o) begin
        pend_q <= 1'b1;
      end
      outstnd_q      <= outstnd_q + CNT_W'(granted) - CNT_W'(resp_valid_o);
      // Stray rvalid, dropped and flagged for one cycle
      protocol_err_o <= rvalid_i && !resp_expected;
    end
  end

  // Capture address of a request the slave did not grant at once
  always_ff @(posedge clk) begin
    if (req_o && !gnt_i && !pend_q) begin
      pend_addr_q <= trans_i.addr;
    end
  end

  a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    req_o && !gnt_i |=> req_o && $stable(addr_o))
    else $error("addr_o changed while waiting for gnt");

endmodule

// ==== design/if_prefetch_buffer.sv ====
// Word fetches only; nothing is requested before the first pc_set, old-stream responses are dropped
`include "if_config.svh"

module if_prefetch_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  if_ctrl_pkg::ctrl_fsm_t ctrl_i,
  input  logic [`IF_XLEN-1:0]    target_i,
  input  logic                   prefetch_ready_i,
  output logic                   prefetch_valid_o,
  output if_bus_pkg::inst_resp_t prefetch_o,
  output logic                   busy_o,
  output logic                   trans_valid_o,
  input  logic                   trans_ready_i,
  output if_bus_pkg::bus_req_t   trans_o,
  input  logic                   resp_valid_i,
  input  if_bus_pkg::bus_resp_t  resp_i
);
  import if_bus_pkg::*;

  localparam int unsigned DEPTH = `IF_BUF_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  inst_resp_t          fifo_q [DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CNT_W-1:0]    fifo_cnt_q;
  logic [CNT_W-1:0]    outstnd_q;    // Handed to the adapter, not yet answered
  logic [CNT_W-1:0]    discard_q;    // Responses still owed to the old stream
  logic [`IF_XLEN-1:0] fetch_addr_q; // Next address to request
  logic [`IF_XLEN-1:0] resp_addr_q;  // Address of next kept response
  logic                fetch_en_q;
  logic                trans_fire;
  logic                fifo_push;
  logic                fifo_pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////////////////////////

  // Every request in flight already owns a FIFO slot
  assign trans_valid_o = fetch_en_q && !ctrl_i.pc_set &&
                         (({1'b0, fifo_cnt_q} + {1'b0, outstnd_q}) < (CNT_W + 1)'(DEPTH));
  assign trans_o       = '{addr: fetch_addr_q};
  assign trans_fire    = trans_valid_o && trans_ready_i;

  //////////////////////////////////////////////////////////////////////
  // FIFO side
  //////////////////////////////////////////////////////////////////////

  assign fifo_push        = resp_valid_i && (discard_q == '0) && !ctrl_i.pc_set;
  assign prefetch_valid_o = (fifo_cnt_q != '0);
  assign fifo_pop         = prefetch_ready_i && prefetch_valid_o && !ctrl_i.pc_set;
  assign busy_o           = (outstnd_q != '0) || trans_valid_o;

  // When empty, addr shows where the stream continues
  always_comb begin
    prefetch_o = fifo_q[rd_ptr_q];
    if (!prefetch_valid_o) begin
      prefetch_o.addr = resp_addr_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q   <= 1'b0;
      fetch_addr_q <= '0;
      resp_addr_q  <= '0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      fifo_cnt_q   <= '0;
      outstnd_q    <= '0;
      discard_q    <= '0;
    end else begin
      outstnd_q <= outstnd_q + CNT_W'(trans_fire) - CNT_W'(resp_valid_i);
      if (ctrl_i.pc_set) begin
        // Flush, restart at target, skip whatever is still in flight
        fetch_en_q   <= 1'b1;
        fetch_addr_q <= target_i;
        resp_addr_q  <= target_i;
        wr_ptr_q     <= '0;
        rd_ptr_q     <= '0;
        fifo_cnt_q   <= '0;
        discard_q    <= outstnd_q - CNT_W'(resp_valid_i);
      end else begin
        if (trans_fire) begin
          fetch_addr_q <= fetch_addr_q + `IF_XLEN'(4);
        end
        if (resp_valid_i && (discard_q != '0)) begin
          discard_q <= discard_q - 1'b1;
        end
        if (fifo_push) begin
          wr_ptr_q    <= ptr_inc(wr_ptr_q);
          resp_addr_q <= resp_addr_q + `IF_XLEN'(4);
        end
        if (fifo_pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        fifo_cnt_q <= fifo_cnt_q + CNT_W'(fifo_push) - CNT_W'(fifo_pop);
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (fifo_push) begin
      fifo_q[wr_ptr_q] <= '{bus_resp: resp_i, addr: resp_addr_q};
    end
  end

  // Slot reservation at request time keeps a push from ever finding the FIFO full
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_push |-> (fifo_cnt_q < CNT_W'(DEPTH)) || fifo_pop)
    else $error("prefetch FIFO overflow");

endmodule

// ==== design/if_dummy_insert.sv ====
// Period 0 turns insertion off; the dummy is an R-type ALU op writing x0, so it has no effect
`include "if_config.svh"

module if_dummy_insert (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [3:0]          period_i,
  input  logic                issued_i,
  output logic                dummy_insert_o,
  output logic [`IF_XLEN-1:0] dummy_word_o
);
  logic [3:0]          cnt_q;   // Real instructions since last dummy
  logic [31:0]         lfsr_q;
  logic [2:0]          funct3;
  logic                alt_op;

  // Due once enough real instructions went by
  assign dummy_insert_o = (period_i != 4'd0) && (cnt_q >= period_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= 4'd0;
      lfsr_q <= `IF_LFSR_SEED;
    end else if (issued_i) begin
      if (dummy_insert_o) begin
        cnt_q  <= 4'd0;
        // Galois step, taps 32 22 2 1
        lfsr_q <= {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
      end else if (period_i != 4'd0) begin
        cnt_q <= cnt_q + 4'd1;
      end else begin
        cnt_q <= 4'd0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Instruction word
  //////////////////////////////////////////////////////////////////////

  assign funct3 = lfsr_q[12:10];
  // SUB and SRA are the only funct7 variants in RV32I
  assign alt_op = lfsr_q[13] && ((funct3 == 3'b000) || (funct3 == 3'b101));

  assign dummy_word_o = {1'b0, alt_op, 5'b00000,  // funct7
                         lfsr_q[9:5],             // rs2
                         lfsr_q[4:0],             // rs1
                         funct3,
                         5'b00000,                // rd = x0
                         7'b0110011};

endmodule

// ==== design/if_stage.sv ====
// Top of IF; kill_if must come with a redirect, dummies reuse the PC of the next real instruction
`include "if_config.svh"

module if_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  if_ctrl_pkg::ctrl_fsm_t  ctrl_fsm_i,
  input  logic [`IF_XLEN-1:0]     boot_addr_i,
  input  logic [`IF_XLEN-1:0]     jump_target_i,
  input  logic [`IF_XLEN-1:0]     branch_target_i,
  input  logic [`IF_XLEN-1:0]     mepc_i,
  input  logic [24:0]             mtvec_base_i,
  input  logic [3:0]              dummy_period_i,
  input  logic                    id_ready_i,
  output if_bus_pkg::if_id_pipe_t if_id_pipe_o,
  output logic                    if_busy_o,
  output logic                    csr_mtvec_init_o,
  output logic                    protocol_err_o,
  output logic                    req_o,
  output logic [`IF_XLEN-1:0]     addr_o,
  input  logic                    gnt_i,
  input  logic                    rvalid_i,
  input  logic                    err_i,
  input  logic [`IF_XLEN-1:0]     rdata_i
);
  import if_bus_pkg::*;

  logic [`IF_XLEN-1:0] target;
  logic                prefetch_valid;
  logic                prefetch_ready;
  inst_resp_t          prefetch_instr;
  logic                trans_valid;
  logic                trans_ready;
  bus_req_t            trans;
  logic                resp_valid;
  bus_resp_t           resp;
  logic                if_valid;
  logic                issued;
  logic                dummy_insert;
  logic [`IF_XLEN-1:0] dummy_word;
  logic                abort_op;
  // IF/ID register pieces
  logic                pipe_valid_q;
  logic                pipe_dummy_q;
  logic                pipe_abort_q;
  logic [`IF_XLEN-1:0] pipe_pc_q;
  logic [`IF_XLEN-1:0] pipe_instr_q;

  if_pc_mux u_pc_mux (
    .ctrl_i          (ctrl_fsm_i),
    .boot_addr_i     (boot_addr_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .mtvec_base_i    (mtvec_base_i),
    .target_o        (target),
    .mtvec_init_o    (csr_mtvec_init_o)
  );

  if_prefetch_buffer u_prefetch_buffer (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_i           (ctrl_fsm_i),
    .target_i         (target),
    .prefetch_ready_i (prefetch_ready),
    .prefetch_valid_o (prefetch_valid),
    .prefetch_o       (prefetch_instr),
    .busy_o           (if_busy_o),
    .trans_valid_o    (trans_valid),
    .trans_ready_i    (trans_ready),
    .trans_o          (trans),
    .resp_valid_i     (resp_valid),
    .resp_i           (resp)
  );

  if_instr_bus u_instr_bus (
    .clk            (clk),
    .rst_n          (rst_n),
    .trans_valid_i  (trans_valid),
    .trans_i        (trans),
    .trans_ready_o  (trans_ready),
    .resp_valid_o   (resp_valid),
    .resp_o         (resp),
    .req_o          (req_o),
    .addr_o         (addr_o),
    .gnt_i          (gnt_i),
    .rvalid_i       (rvalid_i),
    .err_i          (err_i),
    .rdata_i        (rdata_i),
    .protocol_err_o (protocol_err_o)
  );

  if_dummy_insert u_dummy_insert (
    .clk            (clk),
    .rst_n          (rst_n),
    .period_i       (dummy_period_i),
    .issued_i       (issued),
    .dummy_insert_o (dummy_insert),
    .dummy_word_o   (dummy_word)
  );

  //////////////////////////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////////////////////////

  assign if_valid = (prefetch_valid || dummy_insert) && !ctrl_fsm_i.kill_if &&
                    !ctrl_fsm_i.halt_if;
  assign issued   = if_valid && id_ready_i;
  // Kill drains stale entries; a dummy leaves the head in place
  assign prefetch_ready = ctrl_fsm_i.kill_if ||
                          (id_ready_i && !ctrl_fsm_i.halt_if && !dummy_insert);
  assign abort_op = dummy_insert ? 1'b0 : prefetch_instr.bus_resp.err;

  // Valid and flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pipe_valid_q <= 1'b0;
      pipe_dummy_q <= 1'b0;
      pipe_abort_q <= 1'b0;
    end else if (issued) begin
      pipe_valid_q <= 1'b1;
      pipe_dummy_q <= dummy_insert;
      pipe_abort_q <= abort_op;
    end else if (id_ready_i) begin
      pipe_valid_q <= 1'b0;
    end
  end

  // Payload, frozen while ID stalls
  always_ff @(posedge clk) begin
    if (issued) begin
      pipe_pc_q    <= prefetch_instr.addr;
      pipe_instr_q <= dummy_insert ? dummy_word : prefetch_instr.bus_resp.rdata;
    end
  end

  assign if_id_pipe_o = '{instr_valid: pipe_valid_q, pc: pipe_pc_q, instr: pipe_instr_q,
                          dummy: pipe_dummy_q, abort_op: pipe_abort_q};

endmodule

// ==== dv/tb_if_mem.sv ====
// Behavioral instruction slave; in-order responses 1 to 4 cycles after gnt, delays come from the testbench
`include "if_config.svh"

module tb_if_mem (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,
  input  logic [`IF_XLEN-1:0] addr_i,
  input  logic [1:0]          gnt_dly_i,
  input  logic [1:0]          rsp_dly_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output logic                err_o,
  output logic [`IF_XLEN-1:0] rdata_o
);
  logic [`IF_XLEN-1:0] addr_q [$];  // Granted addresses, oldest first
  int unsigned         due_q [$];   // Cycle at which each may answer
  int unsigned         cyc;
  int unsigned         gnt_wait;
  logic                rst_s;
  logic                req_s;
  logic                gnt_s;
  logic                rvalid_s;
  logic [`IF_XLEN-1:0] addr_s;
  logic [1:0]          gnt_dly_s;
  logic [1:0]          rsp_dly_s;

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    err_o    = 1'b0;
    rdata_o  = '0;
    cyc      = 0;
    gnt_wait = 0;
    forever begin
      // All bus inputs are settled by the falling edge
      @(negedge clk);
      rst_s     = rst_n;
      req_s     = req_i;
      addr_s    = addr_i;
      gnt_s     = gnt_o;
      rvalid_s  = rvalid_o;
      gnt_dly_s = gnt_dly_i;
      rsp_dly_s = rsp_dly_i;
      @(posedge clk);
      #1;
      cyc++;
      if (!rst_s) begin
        addr_q.delete();
        due_q.delete();
        gnt_wait = 0;
      end else begin
        // Response taken at this edge
        if (rvalid_s) begin
          void'(addr_q.pop_front());
          void'(due_q.pop_front());
        end
        if (req_s && gnt_s) begin
          addr_q.push_back(addr_s);
          due_q.push_back(cyc + rsp_dly_s);
          gnt_wait = gnt_dly_s;
        end else if (gnt_wait != 0) begin
          gnt_wait--;
        end
      end
      gnt_o    = rst_s && (gnt_wait == 0);
      rvalid_o = (due_q.size() != 0) && (due_q[0] <= cyc);
      if (addr_q.size() != 0) begin
        rdata_o = addr_q[0] ^ 32'hA5A5_0000;
        // Error window 0xF00..0xFFF
        err_o   = (addr_q[0] >= 32'h0000_0F00) && (addr_q[0] <= 32'h0000_0FFF);
      end
    end
  end

endmodule

// ==== dv/tb_if_stage.sv ====
// Self-checking bench for if_stage; every redirect comes with kill_if, first failure ends the run
`include "if_config.svh"

module tb_if_stage;
  import if_ctrl_pkg::*;
  import if_bus_pkg::*;

  typedef enum logic [1:0] {
    FIRST_NONE,
    FIRST_BOOT,
    FIRST_REDIRECT
  } first_e;

  localparam int unsigned SEED       = 41155;
  localparam int unsigned CLK_PERIOD = 10;
  // Cycle budget per phase: boot, jump, irq, error window, dummies
  localparam int unsigned BUDGET     = 64 + 64 + 64 + 128 + 256;

  logic                clk;
  logic                rst_n;
  ctrl_fsm_t           ctrl_fsm;
  logic [`IF_XLEN-1:0] boot_addr;
  logic [`IF_XLEN-1:0] jump_target;
  logic [`IF_XLEN-1:0] branch_target;
  logic [`IF_XLEN-1:0] mepc;
  logic [24:0]         mtvec_base;
  logic [3:0]          dummy_period;
  logic                id_ready;
  if_id_pipe_t         if_id_pipe;
  logic                if_busy;
  logic                csr_mtvec_init;
  logic                protocol_err;
  logic                req;
  logic [`IF_XLEN-1:0] addr;
  logic                gnt;
  logic                rvalid;
  logic                err;
  logic [`IF_XLEN-1:0] rdata;
  logic [1:0]          gnt_dly;
  logic [1:0]          rsp_dly;

  // Reference state, updated on the falling edge
  logic [`IF_XLEN-1:0] exp_pc;
  first_e              first_kind;
  int unsigned         dummy_cnt;
  int unsigned         real_cnt;
  int unsigned         bus_open;
  logic [3:0]          period_prev;
  logic                ready_prev;
  if_id_pipe_t         pipe_prev;
  // Per-cycle check values
  logic                chk_new;
  logic                chk_dummy;
  logic                chk_hold;
  logic                chk_busy;
  logic [`IF_XLEN-1:0] chk_pc;
  first_e              chk_kind;
  if_id_pipe_t         hold_ref;

  if_stage uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_fsm_i       (ctrl_fsm),
    .boot_addr_i      (boot_addr),
    .jump_target_i    (jump_target),
    .branch_target_i  (branch_target),
    .mepc_i           (mepc),
    .mtvec_base_i     (mtvec_base),
    .dummy_period_i   (dummy_period),
    .id_ready_i       (id_ready),
    .if_id_pipe_o     (if_id_pipe),
    .if_busy_o        (if_busy),
    .csr_mtvec_init_o (csr_mtvec_init),
    .protocol_err_o   (protocol_err),
    .req_o            (req),
    .addr_o           (addr),
    .gnt_i            (gnt),
    .rvalid_i         (rvalid),
    .err_i            (err),
    .rdata_i          (rdata)
  );

  tb_if_mem u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (req),
    .addr_i    (addr),
    .gnt_dly_i (gnt_dly),
    .rsp_dly_i (rsp_dly),
    .gnt_o     (gnt),
    .rvalid_o  (rvalid),
    .err_o     (err),
    .rdata_o   (rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference rules
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return a ^ 32'hA5A5_0000;
  endfunction

  function automatic logic in_err_window(input logic [31:0] a);
    return (a >= 32'h0000_0F00) && (a <= 32'h0000_0FFF);
  endfunction

  function automatic logic [31:0] redirect_target(input ctrl_fsm_t c);
    logic [31:0] t;
    case (c.pc_mux)
      PC_BOOT:     t = boot_addr;
      PC_JUMP:     t = jump_target;
      PC_BRANCH:   t = branch_target;
      PC_MRET:     t = mepc;
      PC_TRAP_EXC: t = {mtvec_base, 7'h00};
      PC_TRAP_IRQ: t = {mtvec_base, 7'h00} + 32'(c.irq_index) * 32'd4;
      default:     t = boot_addr;
    endcase
    return t & ~32'h3;
  endfunction

  task automatic halt_on_failure();
    $display("Result: FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
    $display("ERR %s expected %0h actual %0h", name, exp, act);
    halt_on_failure();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Clock, random sources, watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // id_ready about 3 of 4 cycles, bus delays 0..3
  initial begin
    id_ready = 1'b0;
    gnt_dly  = 2'd0;
    rsp_dly  = 2'd0;
    void'($urandom(SEED));
    forever begin
      @(posedge clk);
      #1;
      id_ready = ($urandom % 4) != 0;
      gnt_dly  = 2'($urandom % 4);
      rsp_dly  = 2'($urandom % 4);
    end
  end

  initial begin
    #(20 * BUDGET * CLK_PERIOD);
    $display("Watchdog expired before all phases finished");
    halt_on_failure();
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Entry is new when ID was ready in the cycle before
  always @(negedge clk) begin
    hold_ref  = pipe_prev;
    pipe_prev = if_id_pipe;
    if (!rst_n) begin
      chk_new     = 1'b0;
      chk_dummy   = 1'b0;
      chk_hold    = 1'b0;
      chk_busy    = 1'b0;
      chk_pc      = '0;
      chk_kind    = FIRST_NONE;
      exp_pc      = '0;
      first_kind  = FIRST_NONE;
      dummy_cnt   = 0;
      real_cnt    = 0;
      bus_open    = 0;
    end else begin
      chk_new   = if_id_pipe.instr_valid && ready_prev;
      chk_hold  = !ready_prev;
      chk_dummy = (period_prev != 4'd0) && (dummy_cnt >= period_prev);
      chk_pc    = exp_pc;
      chk_kind  = first_kind;
      // IF counts as busy while it requests or still waits for a response
      chk_busy  = req || (bus_open != 0);
      if (req && gnt) begin
        bus_open++;
      end
      if (rvalid) begin
        bus_open--;
      end
      if (chk_new && chk_dummy) begin
        dummy_cnt = 0;
      end else if (chk_new) begin
        dummy_cnt  = (period_prev != 4'd0) ? dummy_cnt + 1 : 0;
        exp_pc     = exp_pc + 32'd4;
        first_kind = FIRST_NONE;
        real_cnt++;
      end
      // Redirect takes effect for entries after this cycle
      if (ctrl_fsm.pc_set) begin
        exp_pc     = redirect_target(ctrl_fsm);
        first_kind = (ctrl_fsm.pc_mux == PC_BOOT) ? FIRST_BOOT : FIRST_REDIRECT;
      end
    end
    ready_prev  = id_ready;
    period_prev = dummy_period;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_boot_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    chk_new && !chk_dummy && chk_kind == FIRST_BOOT |->
    if_id_pipe.pc == chk_pc && if_id_pipe.instr == mem_word(chk_pc))
    else report_mismatch("boot_fetch", {$sampled(chk_pc), mem_word($sampled(chk_pc))},
                         {$sampled(if_id_pipe.pc), $sampled(if_id_pipe.instr)});

  a_sequential: assert property (@(posedge clk) disable iff (!rst_n)
    chk_new && !chk_dummy && chk_kind == FIRST_NONE |->
    if_id_pipe.pc == chk_pc && if_id_pipe.instr == mem_word(chk_pc))
    else report_mismatch("sequential_stream", {$sampled(chk_pc), mem_word($sampled(chk_pc))},
                         {$sampled(if_id_pipe.pc), $sampled(if_id_pipe.instr)});

  a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    chk_new && !chk_dummy && chk_kind == FIRST_REDIRECT |-> if_id_pipe.pc == chk_pc)
    else report_mismatch("redirect_targets", $sampled(chk_pc), $sampled(if_id_pipe.pc));

  a_mtvec_init: assert property (@(posedge clk) disable iff (!rst_n)
    csr_mtvec_init == (ctrl_fsm.pc_set && ctrl_fsm.pc_mux == PC_BOOT))
    else report_mismatch("boot_fetch", $sampled(ctrl_fsm.pc_set && ctrl_fsm.pc_mux == PC_BOOT),
                         $sampled(csr_mtvec_init));

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    chk_hold |-> if_id_pipe === hold_ref)
    else report_mismatch("backpressure_hold", $sampled(hold_ref), $sampled(if_id_pipe));

  a_abort: assert property (@(posedge clk) disable iff (!rst_n)
    chk_new && !chk_dummy |-> if_id_pipe.abort_op == in_err_window(chk_pc))
    else report_mismatch("bus_error_abort", in_err_window($sampled(chk_pc)),
                         $sampled(if_id_pipe.abort_op));

  a_no_protocol_err: assert property (@(posedge clk) disable iff (!rst_n) !protocol_err)
    else begin
      $display("protocol_err_o rose although the memory answered only open requests");
      halt_on_failure();
    end

  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    if_busy == chk_busy)
    else report_mismatch("if_busy", $sampled(chk_busy), $sampled(if_busy));

  a_dummy_flag: assert property (@(posedge clk) disable iff (!rst_n)
    chk_new |-> if_id_pipe.dummy == chk_dummy)
    else report_mismatch("dummy_insertion", $sampled(chk_dummy), $sampled(if_id_pipe.dummy));

  // Dummy shape: next real pc, no abort, R-type ALU op into x0
  a_dummy_word: assert property (@(posedge clk) disable iff (!rst_n)
    chk_new && chk_dummy |-> if_id_pipe.pc == chk_pc && !if_id_pipe.abort_op &&
    if_id_pipe.instr[6:0] == 7'b0110011 && if_id_pipe.instr[11:7] == 5'd0)
    else report_mismatch("dummy_insertion", {$sampled(chk_pc), 1'b0, 12'h033},
                         {$sampled(if_id_pipe.pc), $sampled(if_id_pipe.abort_op),
                          $sampled(if_id_pipe.instr[11:0])});

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // One-cycle redirect, entered and left just after a rising edge
  task automatic redirect(input pc_mux_e src, input logic [4:0] index);
    ctrl_fsm.pc_set    = 1'b1;
    ctrl_fsm.pc_mux    = src;
    ctrl_fsm.irq_index = index;
    ctrl_fsm.kill_if   = 1'b1;
    @(posedge clk);
    #1;
    ctrl_fsm = '0;
  endtask

  // Wait for n more real entries, watchdog bounds the wait
  task automatic run_entries(input int unsigned n);
    int unsigned goal;
    goal = real_cnt + n;
    while (real_cnt < goal) begin
      @(posedge clk);
    end
    #1;
  endtask

  initial begin
    rst_n         = 1'b0;
    ctrl_fsm      = '0;
    boot_addr     = 32'h0000_0103;
    jump_target   = 32'h0000_0422;
    branch_target = 32'h0000_0800;
    mepc          = 32'h0000_0900;
    mtvec_base    = 25'h00_0040;
    dummy_period  = 4'd0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    // Boot stream from 0x100
    redirect(PC_BOOT, 5'd0);
    run_entries(8);
    // Jump to 0x420
    redirect(PC_JUMP, 5'd0);
    run_entries(8);
    // Vectored interrupt slot 5 at 0x2014
    redirect(PC_TRAP_IRQ, 5'd5);
    run_entries(8);
    // Walk from 0xEF4 into the error window
    jump_target = 32'h0000_0EF4;
    redirect(PC_JUMP, 5'd0);
    run_entries(12);
    // Dummy every fourth issue, then off again
    dummy_period = 4'd3;
    run_entries(16);
    dummy_period = 4'd0;
    run_entries(6);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+design
design/if_ctrl_pkg.sv
design/if_bus_pkg.sv
design/if_pc_mux.sv
design/if_instr_bus.sv
design/if_prefetch_buffer.sv
design/if_dummy_insert.sv
design/if_stage.sv
dv/tb_if_mem.sv
dv/tb_if_stage.sv
